// File: design/usb_tx_pkg.sv
package usb_tx_pkg;

  // ==============================
  // Data path widths
  // ==============================
  localparam int byte_w = 8;
  localparam int bit_idx_w = 3;

  // SYNC is KJKJKJKK on the line, sent LSB first
  localparam logic [byte_w-1:0] sync_byte = 8'h80;

  // ==============================
  // Line coding
  // ==============================
  localparam int stuff_limit = 6;
  localparam int stuff_cnt_w = 3;
  localparam int eop_se0_bits = 2;

  // Clocks per full-speed bit
  localparam int bit_period = 4;

  // Packet sequencer states
  typedef enum logic [2:0] {
    tx_idle,
    tx_sync,
    tx_data,
    tx_eop,
    tx_done
  } tx_state_t;

endpackage

// File: design/tx_byte_if.sv
`timescale 1ns/1ns

interface tx_byte_if;

  // Four-phase byte transfer where last marks the packet end item
  logic                          req;
  logic                          ack;
  logic [usb_tx_pkg::byte_w-1:0] data;
  logic                          last;

  modport source (
    output req,
    output data,
    output last,
    input  ack
  );

  modport sink (
    input  req,
    input  data,
    input  last,
    output ack
  );

endinterface

// File: design/tx_bit_if.sv
`timescale 1ns/1ns

interface tx_bit_if;

  logic ser_bit;
  logic active;
  logic eop;
  // Stuffed zero on the line this bit
  logic hold;
  logic eop_done;

  modport src (
    output ser_bit,
    output active,
    output eop,
    input  hold,
    input  eop_done
  );

  modport enc (
    input  ser_bit,
    input  active,
    input  eop,
    output hold,
    output eop_done
  );

endinterface

// File: design/bit_strobe_gen.sv
`timescale 1ns/1ns

module bit_strobe_gen (
  input  logic i_rx_phy_clk,
  input  logic i_tx_phy_rst,
  output logic o_bit_stb
);

  localparam int cnt_w = $clog2(usb_tx_pkg::bit_period);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(usb_tx_pkg::bit_period - 1);

  logic [cnt_w-1:0] phase_cnt;

  // Free running with no lock to any received edge
  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
  begin
    if (!i_tx_phy_rst)
    begin
      phase_cnt <= '0;
      o_bit_stb <= 1'b0;
    end
    else
    begin
      phase_cnt <= (phase_cnt == cnt_max) ? '0 : phase_cnt + 1'b1;
      o_bit_stb <= (phase_cnt == cnt_max);
    end
  end

endmodule

// File: design/tx_packet_sequencer.sv
`timescale 1ns/1ns

module tx_packet_sequencer (
  input  logic                          i_rx_phy_clk,
  input  logic                          i_tx_phy_rst,
  input  logic                          i_tx_valid,
  input  logic [usb_tx_pkg::byte_w-1:0] i_tx_data,
  output logic                          o_tx_ready,
  tx_byte_if.source                     byte_port
);

  usb_tx_pkg::tx_state_t state;

  // Host byte passes straight through and is held until o_tx_ready
  assign byte_port.data = (state == usb_tx_pkg::tx_sync) ? usb_tx_pkg::sync_byte : i_tx_data;
  assign byte_port.last = (state == usb_tx_pkg::tx_eop);

  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
  begin
    if (!i_tx_phy_rst)
    begin
      state         <= usb_tx_pkg::tx_idle;
      byte_port.req <= 1'b0;
      o_tx_ready    <= 1'b0;
    end
    else
    begin
      o_tx_ready <= 1'b0;
      if (byte_port.req)
      begin
        // Phase 3 of the handshake
        if (byte_port.ack)
        begin
          byte_port.req <= 1'b0;
          o_tx_ready    <= (state == usb_tx_pkg::tx_data);
          if (state == usb_tx_pkg::tx_sync)
            state <= usb_tx_pkg::tx_data;
          else if (state == usb_tx_pkg::tx_eop)
            state <= usb_tx_pkg::tx_done;
        end
      end
      else if (!byte_port.ack)
      begin
        case (state)
          usb_tx_pkg::tx_idle:
            if (i_tx_valid)
              state <= usb_tx_pkg::tx_sync;
          usb_tx_pkg::tx_sync:
            byte_port.req <= 1'b1;
          usb_tx_pkg::tx_data:
            if (i_tx_valid)
              byte_port.req <= 1'b1;
            else
              state <= usb_tx_pkg::tx_eop;
          usb_tx_pkg::tx_eop:
            byte_port.req <= 1'b1;
          usb_tx_pkg::tx_done:
            state <= usb_tx_pkg::tx_idle;
          default:
            state <= usb_tx_pkg::tx_idle;
        endcase
      end
    end
  end

endmodule

// File: design/tx_byte_serializer.sv
`timescale 1ns/1ns

module tx_byte_serializer (
  input  logic     i_rx_phy_clk,
  input  logic     i_tx_phy_rst,
  input  logic     i_bit_stb,
  tx_byte_if.sink  byte_port,
  tx_bit_if.src    bit_port
);

  localparam logic [usb_tx_pkg::bit_idx_w-1:0] last_idx = '1;

  logic [usb_tx_pkg::byte_w-1:0]    hold_data;
  logic [usb_tx_pkg::byte_w-1:0]    shift_data;
  logic [usb_tx_pkg::bit_idx_w-1:0] bit_cnt;
  logic hold_full;
  logic eop_fin;
  logic take_byte;
  logic take_last;
  logic advance;
  logic byte_end;
  logic load_shift;

  assign take_byte = byte_port.req & ~byte_port.last & ~byte_port.ack & ~hold_full;
  // End item is acked only once the EOP is on the line
  assign take_last = byte_port.req & byte_port.last & ~byte_port.ack & eop_fin;

  assign advance    = i_bit_stb & bit_port.active & ~bit_port.hold;
  assign byte_end   = advance & (bit_cnt == last_idx);
  assign load_shift = hold_full & (byte_end |
                      (i_bit_stb & ~bit_port.active & ~bit_port.eop & ~eop_fin));

  assign bit_port.ser_bit = shift_data[0];

  always_ff @(posedge i_rx_phy_clk)
  begin
    if (take_byte)
      hold_data <= byte_port.data;
    if (load_shift)
      shift_data <= hold_data;
    else if (advance)
      shift_data <= shift_data >> 1;
  end

  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
  begin
    if (!i_tx_phy_rst)
    begin
      hold_full       <= 1'b0;
      eop_fin         <= 1'b0;
      bit_cnt         <= '0;
      bit_port.active <= 1'b0;
      bit_port.eop    <= 1'b0;
      byte_port.ack   <= 1'b0;
    end
    else
    begin
      if (take_byte)
        hold_full <= 1'b1;
      else if (load_shift)
        hold_full <= 1'b0;

      if (take_byte | take_last)
        byte_port.ack <= 1'b1;
      else if (!byte_port.req)
        byte_port.ack <= 1'b0;

      // ==============================
      // Bit walk and byte boundary
      // ==============================
      if (load_shift)
      begin
        bit_port.active <= 1'b1;
        bit_cnt         <= '0;
      end
      else if (byte_end)
      begin
        bit_port.active <= 1'b0;
        bit_port.eop    <= 1'b1;
      end
      else if (advance)
        bit_cnt <= bit_cnt + 1'b1;

      if (bit_port.eop_done)
      begin
        bit_port.eop <= 1'b0;
        eop_fin      <= 1'b1;
      end
      else if (take_last)
        eop_fin <= 1'b0;
    end
  end

endmodule

// File: design/tx_line_encoder.sv
`timescale 1ns/1ns

module tx_line_encoder (
  input  logic   i_rx_phy_clk,
  input  logic   i_tx_phy_rst,
  input  logic   i_bit_stb,
  input  logic   i_phy_mode,
  tx_bit_if.enc  bit_port,
  output logic   o_txdp,
  output logic   o_txdn,
  output logic   o_txoe
);

  localparam int eop_cnt_w = $clog2(usb_tx_pkg::eop_se0_bits + 2);
  localparam logic [eop_cnt_w-1:0] j_slot = eop_cnt_w'(usb_tx_pkg::eop_se0_bits);
  localparam logic [usb_tx_pkg::stuff_cnt_w-1:0] ones_max =
    usb_tx_pkg::stuff_cnt_w'(usb_tx_pkg::stuff_limit);

  logic [usb_tx_pkg::stuff_cnt_w-1:0] ones_cnt;
  logic [usb_tx_pkg::stuff_cnt_w-1:0] nxt_ones;
  logic [eop_cnt_w-1:0] eop_cnt;
  logic [eop_cnt_w-1:0] nxt_eop_cnt;
  logic nrzi;
  logic nxt_nrzi;
  logic nxt_se0;
  logic nxt_oe;
  logic nxt_done;

  assign bit_port.hold = (ones_cnt == ones_max);

  // ==============================
  // Next line state
  // ==============================
  always_comb
  begin
    nxt_nrzi    = nrzi;
    nxt_se0     = 1'b0;
    nxt_oe      = 1'b0;
    nxt_ones    = '0;
    nxt_eop_cnt = '0;
    nxt_done    = 1'b0;
    if (bit_port.hold)
      nxt_nrzi = ~nrzi;
    else if (bit_port.active)
    begin
      // Zero toggles the line, one keeps it
      if (bit_port.ser_bit)
        nxt_ones = ones_cnt + 1'b1;
      else
        nxt_nrzi = ~nrzi;
    end
    else if (bit_port.eop)
    begin
      nxt_eop_cnt = eop_cnt + 1'b1;
      if (eop_cnt < j_slot)
        nxt_se0 = 1'b1;
      else if (eop_cnt == j_slot)
        nxt_nrzi = 1'b1;
      else
      begin
        nxt_oe      = 1'b1;
        nxt_eop_cnt = '0;
        nxt_done    = 1'b1;
      end
    end
    else
    begin
      nxt_nrzi = 1'b1;
      nxt_oe   = 1'b1;
    end
  end

  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
  begin
    if (!i_tx_phy_rst)
    begin
      nrzi              <= 1'b1;
      ones_cnt          <= '0;
      eop_cnt           <= '0;
      bit_port.eop_done <= 1'b0;
      o_txoe            <= 1'b1;
      o_txdp            <= 1'b1;
      o_txdn            <= 1'b0;
    end
    else
    begin
      bit_port.eop_done <= i_bit_stb & nxt_done;
      if (i_bit_stb)
      begin
        nrzi     <= nxt_nrzi;
        ones_cnt <= nxt_ones;
        eop_cnt  <= nxt_eop_cnt;
        o_txoe   <= nxt_oe;
        // Differential pins, or data plus SE0 flag
        o_txdp   <= i_phy_mode ? (nxt_nrzi & ~nxt_se0) : nxt_nrzi;
        o_txdn   <= i_phy_mode ? (~nxt_nrzi & ~nxt_se0) : nxt_se0;
      end
    end
  end

endmodule

// File: design/usb_tx_phy.sv
`timescale 1ns/1ns

module usb_tx_phy (
  input  logic                          i_rx_phy_clk,
  input  logic                          i_tx_phy_rst,
  input  logic                          i_phy_mode,
  input  logic                          i_tx_valid,
  input  logic [usb_tx_pkg::byte_w-1:0] i_tx_data,
  output logic                          o_tx_ready,
  output logic                          o_txdp,
  output logic                          o_txdn,
  output logic                          o_txoe
);

  logic bit_stb;

  tx_byte_if byte_bus ();
  tx_bit_if  bit_bus ();

  bit_strobe_gen u_bit_strobe_gen (
    .i_rx_phy_clk (i_rx_phy_clk),
    .i_tx_phy_rst (i_tx_phy_rst),
    .o_bit_stb    (bit_stb)
  );

  tx_packet_sequencer u_tx_packet_sequencer (
    .i_rx_phy_clk (i_rx_phy_clk),
    .i_tx_phy_rst (i_tx_phy_rst),
    .i_tx_valid   (i_tx_valid),
    .i_tx_data    (i_tx_data),
    .o_tx_ready   (o_tx_ready),
    .byte_port    (byte_bus.source)
  );

  tx_byte_serializer u_tx_byte_serializer (
    .i_rx_phy_clk (i_rx_phy_clk),
    .i_tx_phy_rst (i_tx_phy_rst),
    .i_bit_stb    (bit_stb),
    .byte_port    (byte_bus.sink),
    .bit_port     (bit_bus.src)
  );

  tx_line_encoder u_tx_line_encoder (
    .i_rx_phy_clk (i_rx_phy_clk),
    .i_tx_phy_rst (i_tx_phy_rst),
    .i_bit_stb    (bit_stb),
    .i_phy_mode   (i_phy_mode),
    .bit_port     (bit_bus.enc),
    .o_txdp       (o_txdp),
    .o_txdn       (o_txdn),
    .o_txoe       (o_txoe)
  );

endmodule

// File: bench/usb_tx_phy_assertions.sv
`timescale 1ns/1ns

module usb_tx_phy_assertions (
  input logic i_rx_phy_clk,
  input logic i_tx_phy_rst,
  input logic i_phy_mode,
  input logic i_tx_ready,
  input logic i_txdp,
  input logic i_txdn,
  input logic i_txoe
);

  int fail_cnt = 0;

  ready_one_clock: assert property (@(posedge i_rx_phy_clk) disable iff (!i_tx_phy_rst)
    i_tx_ready |=> !i_tx_ready)
    else
    begin
      $error("o_tx_ready high on two consecutive clocks");
      fail_cnt++;
    end

  // Both pins high is not a legal differential state
  diff_not_se1: assert property (@(posedge i_rx_phy_clk) disable iff (!i_tx_phy_rst)
    i_phy_mode |-> !(i_txdp && i_txdn))
    else
    begin
      $error("txdp and txdn both high in differential mode");
      fail_cnt++;
    end

  pins_quiet_idle: assert property (@(posedge i_rx_phy_clk) disable iff (!i_tx_phy_rst)
    ($changed(i_txdp) || $changed(i_txdn)) |-> (!i_txoe || $rose(i_txoe)))
    else
    begin
      $error("line pins moved while output enable was inactive");
      fail_cnt++;
    end

endmodule

bind usb_tx_phy usb_tx_phy_assertions u_assertions (
  .i_rx_phy_clk (i_rx_phy_clk),
  .i_tx_phy_rst (i_tx_phy_rst),
  .i_phy_mode   (i_phy_mode),
  .i_tx_ready   (o_tx_ready),
  .i_txdp       (o_txdp),
  .i_txdn       (o_txdn),
  .i_txoe       (o_txoe)
);

// File: bench/tx_line_checker.sv
`timescale 1ns/1ns

module tx_line_checker (
  input logic i_rx_phy_clk,
  input logic i_tx_phy_rst,
  input logic i_phy_mode,
  input logic i_tx_ready,
  input logic i_txdp,
  input logic i_txdn,
  input logic i_txoe
);

  localparam int max_line_bits = 100;

  logic [usb_tx_pkg::byte_w-1:0] exp_q [$];
  int len_q [$];
  int line_errs = 0;
  int hs_errs = 0;
  int other_errs = 0;
  int pkts_done = 0;
  int ready_total = 0;
  int ready_base = 0;

  task automatic add_byte(input logic [usb_tx_pkg::byte_w-1:0] b);
    exp_q.push_back(b);
  endtask

  task automatic add_packet(input int n);
    len_q.push_back(n);
  endtask

  task automatic note_failure(input string msg);
    $display("%s", msg);
    other_errs++;
  endtask

  always @(negedge i_rx_phy_clk)
  begin
    if (i_tx_phy_rst && i_tx_ready)
      ready_total++;
  end

  // ==============================
  // Line decode of one packet
  // ==============================
  task automatic decode_packet();
    logic [usb_tx_pkg::byte_w-1:0] got_q [$];
    logic [usb_tx_pkg::byte_w-1:0] shreg;
    logic [usb_tx_pkg::byte_w-1:0] e;
    logic prev_level;
    logic b;
    logic se0;
    logic done;
    int ones;
    int se0_cnt;
    int nbits;
    int nsamp;
    int n;
    prev_level = 1'b1;
    shreg = '0;
    done = 1'b0;
    ones = 0;
    se0_cnt = 0;
    nbits = 0;
    nsamp = 0;
    while (!done)
    begin
      se0 = i_phy_mode ? (!i_txdp && !i_txdn) : i_txdn;
      if (i_txoe !== 1'b0)
      begin
        note_failure("output enable went inactive before the end of the EOP");
        done = 1'b1;
      end
      else if (se0)
        se0_cnt++;
      else if (se0_cnt > 0)
      begin
        // J bit closes the EOP
        if (se0_cnt != usb_tx_pkg::eop_se0_bits)
        begin
          $display("ERR o_txdn SE0 bit count got %h exp %h", se0_cnt, usb_tx_pkg::eop_se0_bits);
          line_errs++;
        end
        if (i_txdp !== 1'b1)
        begin
          $display("ERR o_txdp EOP J bit got %h exp 1", i_txdp);
          line_errs++;
        end
        done = 1'b1;
      end
      else
      begin
        if (i_phy_mode && (i_txdn !== !i_txdp))
        begin
          $display("ERR o_txdn got %h exp %h", i_txdn, !i_txdp);
          line_errs++;
        end
        b = (i_txdp == prev_level);
        prev_level = i_txdp;
        if (ones == usb_tx_pkg::stuff_limit)
        begin
          if (b)
          begin
            $display("ERR o_txdp stuffed bit got %h exp 0", b);
            line_errs++;
          end
          ones = 0;
        end
        else
        begin
          ones = b ? ones + 1 : 0;
          shreg = {b, shreg[usb_tx_pkg::byte_w-1:1]};
          nbits++;
          if (nbits % usb_tx_pkg::byte_w == 0)
            got_q.push_back(shreg);
        end
      end
      nsamp++;
      if (!done && nsamp > max_line_bits)
      begin
        note_failure("packet on the line never reached an EOP");
        done = 1'b1;
      end
      if (!done)
        repeat (usb_tx_pkg::bit_period) @(negedge i_rx_phy_clk);
    end

    repeat (usb_tx_pkg::bit_period - 1) @(negedge i_rx_phy_clk);
    if (i_txoe !== 1'b1)
    begin
      $display("ERR o_txoe after EOP got %h exp 1", i_txoe);
      line_errs++;
    end

    if (nbits % usb_tx_pkg::byte_w != 0)
      note_failure("packet ended in the middle of a byte");
    if (got_q.size() == 0)
      note_failure("packet carried no SYNC byte");
    else if (got_q[0] != usb_tx_pkg::sync_byte)
    begin
      $display("ERR o_txdp SYNC got %h exp %h", got_q[0], usb_tx_pkg::sync_byte);
      line_errs++;
    end

    if (len_q.size() == 0)
      note_failure("packet appeared on the line that the host never sent");
    else
    begin
      n = len_q.pop_front();
      if (got_q.size() != n + 1)
      begin
        $display("ERR i_tx_data byte count got %h exp %h", got_q.size() - 1, n);
        line_errs++;
      end
      for (int i = 0; i < n; i++)
      begin
        e = exp_q.pop_front();
        if (i + 1 < got_q.size() && got_q[i + 1] != e)
        begin
          $display("ERR i_tx_data byte %0d got %h exp %h", i, got_q[i + 1], e);
          line_errs++;
        end
      end
      if (ready_total - ready_base != n)
      begin
        $display("ERR o_tx_ready pulses got %h exp %h", ready_total - ready_base, n);
        hs_errs++;
      end
    end
    ready_base = ready_total;
    pkts_done++;
  endtask

  initial
  begin
    wait (i_tx_phy_rst === 1'b1);
    @(negedge i_rx_phy_clk);
    if (i_txoe !== 1'b1 || i_txdp !== 1'b1 || i_txdn !== 1'b0 || i_tx_ready !== 1'b0)
    begin
      $display("ERR o_txoe/o_txdp/o_txdn/o_tx_ready after reset got %h%h%h%h exp 1100",
               i_txoe, i_txdp, i_txdn, i_tx_ready);
      line_errs++;
    end
    forever
    begin
      @(negedge i_rx_phy_clk);
      while (i_txoe !== 1'b0)
        @(negedge i_rx_phy_clk);
      // Mid-bit sampling from here on
      @(negedge i_rx_phy_clk);
      decode_packet();
    end
  end

endmodule

// File: bench/tb_usb_tx_phy.sv
`timescale 1ns/1ns

module tb_usb_tx_phy;

  localparam int num_pkts = 40;
  localparam int max_pkt_bytes = 6;
  localparam int max_pkt_bits = 80;
  localparam int clk_period = 8;
  localparam int watchdog_ns = num_pkts * max_pkt_bits * usb_tx_pkg::bit_period * clk_period * 2;

  logic clk;
  logic rst_n;
  logic phy_mode;
  logic tx_valid;
  logic [usb_tx_pkg::byte_w-1:0] tx_data;
  logic tx_ready;
  logic txdp;
  logic txdn;
  logic txoe;
  integer seed;

  usb_tx_phy DUT (
    .i_rx_phy_clk (clk),
    .i_tx_phy_rst (rst_n),
    .i_phy_mode   (phy_mode),
    .i_tx_valid   (tx_valid),
    .i_tx_data    (tx_data),
    .o_tx_ready   (tx_ready),
    .o_txdp       (txdp),
    .o_txdn       (txdn),
    .o_txoe       (txoe)
  );

  tx_line_checker u_checker (
    .i_rx_phy_clk (clk),
    .i_tx_phy_rst (rst_n),
    .i_phy_mode   (phy_mode),
    .i_tx_ready   (tx_ready),
    .i_txdp       (txdp),
    .i_txdn       (txdn),
    .i_txoe       (txoe)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(clk_period / 2) clk = ~clk;
  end

  task automatic report_and_finish();
    int total;
    total = u_checker.line_errs + u_checker.hs_errs + u_checker.other_errs +
            DUT.u_assertions.fail_cnt;
    $display("errors: line %0d, handshake %0d, other %0d, assertion %0d",
             u_checker.line_errs, u_checker.hs_errs, u_checker.other_errs,
             DUT.u_assertions.fail_cnt);
    if (total == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  // ==============================
  // One host packet
  // ==============================
  task automatic send_packet(input int idx);
    int len;
    int gap;
    logic ones_heavy;
    logic [usb_tx_pkg::byte_w-1:0] b;
    len = int'($unsigned($random(seed)) % max_pkt_bytes) + 1;
    ones_heavy = (($random(seed) & 3) == 0);
    gap = int'($unsigned($random(seed)) % 6);
    @(negedge clk);
    phy_mode = 1'($random(seed));
    u_checker.add_packet(len);
    for (int i = 0; i < len; i++)
    begin
      b = 8'($random(seed));
      // FF bytes force stuffed bits
      if (ones_heavy && (($random(seed) & 1) == 1))
        b = 8'hff;
      u_checker.add_byte(b);
      tx_data = b;
      tx_valid = 1'b1;
      @(negedge clk);
      while (tx_ready !== 1'b1)
        @(negedge clk);
    end
    tx_valid = 1'b0;
    while (u_checker.pkts_done < idx + 1 || txoe !== 1'b1)
      @(negedge clk);
    repeat (gap) @(negedge clk);
  endtask

  initial
  begin
    seed = 32'h2472;
    rst_n = 1'b0;
    phy_mode = 1'b1;
    tx_valid = 1'b0;
    tx_data = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);
    for (int p = 0; p < num_pkts; p++)
      send_packet(p);
    repeat (4 * usb_tx_pkg::bit_period) @(negedge clk);
    report_and_finish();
  end

  initial
  begin
    #(watchdog_ns);
    u_checker.note_failure("timeout: packets did not finish in the expected time");
    report_and_finish();
  end

endmodule

// File: verilog.f
design/usb_tx_pkg.sv
design/tx_byte_if.sv
design/tx_bit_if.sv
design/bit_strobe_gen.sv
design/tx_packet_sequencer.sv
design/tx_byte_serializer.sv
design/tx_line_encoder.sv
design/usb_tx_phy.sv
bench/usb_tx_phy_assertions.sv
bench/tx_line_checker.sv
bench/tb_usb_tx_phy.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_usb_tx_phy \
  -f verilog.f &&
./obj_dir/Vtb_usb_tx_phy | tee /dev/stderr | grep -qx "sim passed" &&
echo "run ok" || { echo "run failed"; exit 1; }
